// ==== icache_pkg.sv ====
// icache shared definitions
// default widths, bus response codes and the controller state encoding
// a line is a single 64-bit word, so the byte offset width is fixed

package icache_pkg;

  // default geometry, overridden through the top level parameters
  localparam int ADDR_W_DEF  = 32;  // physical address, one word
  localparam int INDEX_W_DEF = 6;   // 64 sets
  localparam int DATA_W_DEF  = 64;  // one word per line

  // byte offset inside the 8-byte line, ignored on lookup
  localparam int OFFSET_W = 3;

  // response code carried on both read data channels
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } resp_t;

  // controller states
  // HIT also serves as the response state after a refill
  typedef enum logic [1:0] {
    IDLE   = 2'd0,  // waiting for a fetch request
    HIT    = 2'd1,  // RAM read and response to the CPU
    MEM_AR = 2'd2,  // refill address phase
    MEM_R  = 2'd3   // refill data phase
  } ctrl_state_t;

endpackage

// ==== icache_data_ram.sv ====
// icache data RAM
// behavioral single-port synchronous RAM standing in for the SRAM macro
// one instance per way, one line word per entry
// read data appears one cycle after an enabled read and holds otherwise

module icache_data_ram #(
  parameter int INDEX_W = 6,
  parameter int DATA_W  = 64
) (
  input  logic               clk,
  input  logic               ce_i,     // chip enable
  input  logic               we_i,     // 1 write, 0 read
  input  logic [INDEX_W-1:0] addr_i,
  input  logic [DATA_W-1:0]  wdata_i,
  output logic [DATA_W-1:0]  rdata_o
);

  localparam int DEPTH = 1 << INDEX_W;

  logic [DATA_W-1:0] mem_q [DEPTH];

  always_ff @(posedge clk) begin
    if (ce_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;  // rdata_o keeps its last read
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== icache_tag_store.sv ====
// icache tag store
// tag and valid arrays for both ways with a combinational hit compare
// a miss allocates an entry (tag written, valid cleared) and a good
// refill later validates exactly that entry

module icache_tag_store import icache_pkg::*; #(
  parameter int ADDR_W  = 32,
  parameter int INDEX_W = 6
) (
  input  logic                                clk,
  input  logic                                rst,
  // lookup, straight from the fetch address
  input  logic [INDEX_W-1:0]                  lookup_index_i,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]  lookup_tag_i,
  output logic                                hit_o,
  output logic                                hit_way_o,
  // allocation on a miss
  input  logic                                alloc_en_i,
  input  logic                                alloc_way_i,
  input  logic [INDEX_W-1:0]                  alloc_index_i,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]  alloc_tag_i,
  // refill finished with OKAY
  input  logic                                validate_en_i
);

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
  localparam int DEPTH = 1 << INDEX_W;

  logic [TAG_W-1:0]   tag_q   [2][DEPTH];
  logic [DEPTH-1:0]   valid_q [2];
  logic               alloc_way_q;    // entry waiting for its refill
  logic [INDEX_W-1:0] alloc_index_q;
  logic [1:0]         way_hit;

  // compare both ways in the same cycle
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_q[w][lookup_index_i] &&
                   (tag_q[w][lookup_index_i] == lookup_tag_i);
    end
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit[1];  // both ways never hold the same tag

  // tags and the pending entry carry no reset
  always_ff @(posedge clk) begin
    if (alloc_en_i) begin
      tag_q[alloc_way_i][alloc_index_i] <= alloc_tag_i;
      alloc_way_q                       <= alloc_way_i;
      alloc_index_q                     <= alloc_index_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
    end else begin
      if (alloc_en_i) begin
        valid_q[alloc_way_i][alloc_index_i] <= 1'b0;  // old line is gone
      end
      if (validate_en_i) begin
        valid_q[alloc_way_q][alloc_index_q] <= 1'b1;
      end
    end
  end

endmodule

// ==== icache_ctrl.sv ====
// icache controller
// lookup and refill FSM between the CPU fetch port and the memory port
// hits return after a fixed two-cycle RAM read, misses refill one line
// replacement way comes from a free-running one-bit counter

module icache_ctrl import icache_pkg::*; #(
  parameter int ADDR_W  = 32,
  parameter int INDEX_W = 6,
  parameter int DATA_W  = 64
) (
  input  logic                                clk,
  input  logic                                rst,
  // CPU fetch port
  input  logic                                ar_valid_i,
  output logic                                ar_ready_o,
  input  logic [ADDR_W-1:0]                   ar_addr_i,
  output logic                                r_valid_o,
  input  logic                                r_ready_i,
  output logic [DATA_W-1:0]                   r_data_o,
  output logic [1:0]                          r_resp_o,
  // memory read port
  output logic                                mem_ar_valid_o,
  input  logic                                mem_ar_ready_i,
  output logic [ADDR_W-1:0]                   mem_ar_addr_o,
  input  logic                                mem_r_valid_i,
  output logic                                mem_r_ready_o,
  input  logic [DATA_W-1:0]                   mem_r_data_i,
  input  logic [1:0]                          mem_r_resp_i,
  // tag store
  output logic [INDEX_W-1:0]                  lookup_index_o,
  output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]  lookup_tag_o,
  input  logic                                hit_i,
  input  logic                                hit_way_i,
  output logic                                alloc_en_o,
  output logic                                alloc_way_o,
  output logic [INDEX_W-1:0]                  alloc_index_o,
  output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]  alloc_tag_o,
  output logic                                validate_en_o,
  // data RAMs
  output logic [1:0]                          ram_ce_o,
  output logic                                ram_we_o,
  output logic [INDEX_W-1:0]                  ram_addr_o,
  output logic [DATA_W-1:0]                   ram_wdata_o,
  input  logic [DATA_W-1:0]                   ram0_rdata_i,
  input  logic [DATA_W-1:0]                   ram1_rdata_i
);

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  ctrl_state_t        state_q;
  ctrl_state_t        state_d;
  logic               repl_q;       // replacement way
  logic               way_q;        // way of the request in flight
  logic [INDEX_W-1:0] index_q;
  logic               rd_issued_q;  // hit read sent to the RAM

  logic               accept;
  logic               mem_ar_hs;
  logic               mem_r_hs;
  logic               r_hs;
  logic               hit_read;
  logic               hit_capture;
  logic [DATA_W-1:0]  rdata_sel;
  resp_t              refill_resp;

  assign accept    = ar_valid_i & ar_ready_o;
  assign mem_ar_hs = mem_ar_valid_o & mem_ar_ready_i;
  assign mem_r_hs  = mem_r_valid_i & mem_r_ready_o;
  assign r_hs      = r_valid_o & r_ready_i;

  // first HIT cycle reads the RAM, the second one takes its output
  assign hit_read    = (state_q == HIT) & ~r_valid_o & ~rd_issued_q;
  assign hit_capture = (state_q == HIT) & rd_issued_q;

  // lookup comes straight from the request address
  assign lookup_index_o = ar_addr_i[OFFSET_W +: INDEX_W];
  assign lookup_tag_o   = ar_addr_i[ADDR_W-1 -: TAG_W];

  // a miss claims the entry at accept time
  assign alloc_en_o    = accept & ~hit_i;
  assign alloc_way_o   = repl_q;
  assign alloc_index_o = lookup_index_o;
  assign alloc_tag_o   = lookup_tag_o;

  assign refill_resp   = resp_t'(mem_r_resp_i);
  assign validate_en_o = mem_r_hs & (refill_resp == OKAY);  // errors stay invalid

  // RAM access: read on a hit, write on the refill handshake
  assign ram_we_o    = mem_r_hs;
  assign ram_ce_o[0] = (hit_read | mem_r_hs) & ~way_q;
  assign ram_ce_o[1] = (hit_read | mem_r_hs) & way_q;
  assign ram_addr_o  = index_q;
  assign ram_wdata_o = mem_r_data_i;

  assign rdata_sel = way_q ? ram1_rdata_i : ram0_rdata_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      repl_q <= 1'b0;
    end else begin
      repl_q <= ~repl_q;  // toggles every cycle
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = hit_i ? HIT : MEM_AR;
        end
      end
      HIT: begin
        if (r_hs) begin
          state_d = IDLE;
        end
      end
      MEM_AR: begin
        if (mem_ar_hs) begin
          state_d = MEM_R;
        end
      end
      MEM_R: begin
        if (mem_r_hs) begin
          state_d = HIT;  // wait there for the CPU to take the word
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= IDLE;
      ar_ready_o     <= 1'b1;
      r_valid_o      <= 1'b0;
      mem_ar_valid_o <= 1'b0;
      mem_r_ready_o  <= 1'b0;
      rd_issued_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      case (state_q)
        IDLE: begin
          if (accept) begin
            ar_ready_o     <= 1'b0;  // one request in flight
            mem_ar_valid_o <= ~hit_i;
          end
        end
        HIT: begin
          if (r_hs) begin
            r_valid_o  <= 1'b0;
            ar_ready_o <= 1'b1;
          end else if (hit_read) begin
            rd_issued_q <= 1'b1;
          end else if (hit_capture) begin
            rd_issued_q <= 1'b0;
            r_valid_o   <= 1'b1;
          end
        end
        MEM_AR: begin
          if (mem_ar_hs) begin
            mem_ar_valid_o <= 1'b0;
            mem_r_ready_o  <= 1'b1;
          end
        end
        MEM_R: begin
          if (mem_r_hs) begin
            mem_r_ready_o <= 1'b0;
            r_valid_o     <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      way_q         <= hit_i ? hit_way_i : repl_q;
      index_q       <= lookup_index_o;
      mem_ar_addr_o <= {ar_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned
    end
    if (mem_r_hs) begin
      r_data_o <= mem_r_data_i;
      r_resp_o <= mem_r_resp_i;  // error passed on to the CPU
    end else if (hit_capture) begin
      r_data_o <= rdata_sel;
      r_resp_o <= OKAY;
    end
  end

endmodule

// ==== icache_top.sv ====
// icache top level
// two-way set-associative read-only instruction cache
// ties the controller, the tag store and one data RAM per way together

module icache_top import icache_pkg::*; #(
  parameter int ADDR_W  = ADDR_W_DEF,
  parameter int INDEX_W = INDEX_W_DEF,
  parameter int DATA_W  = DATA_W_DEF
) (
  input  logic              clk,
  input  logic              rst,
  // CPU fetch port
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ADDR_W-1:0] ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  // memory read port
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output logic [ADDR_W-1:0] mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  logic [DATA_W-1:0] mem_r_data_i,
  input  logic [1:0]        mem_r_resp_i
);

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  logic [INDEX_W-1:0] lookup_index;
  logic [TAG_W-1:0]   lookup_tag;
  logic               hit;
  logic               hit_way;
  logic               alloc_en;
  logic               alloc_way;
  logic [INDEX_W-1:0] alloc_index;
  logic [TAG_W-1:0]   alloc_tag;
  logic               validate_en;
  logic [1:0]         ram_ce;
  logic               ram_we;
  logic [INDEX_W-1:0] ram_addr;
  logic [DATA_W-1:0]  ram_wdata;
  logic [DATA_W-1:0]  ram0_rdata;
  logic [DATA_W-1:0]  ram1_rdata;

  icache_ctrl #(
    .ADDR_W (ADDR_W),
    .INDEX_W(INDEX_W),
    .DATA_W (DATA_W)
  ) i_icache_ctrl (
    .clk           (clk),
    .rst           (rst),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_o    (ar_ready_o),
    .ar_addr_i     (ar_addr_i),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .r_data_o      (r_data_o),
    .r_resp_o      (r_resp_o),
    .mem_ar_valid_o(mem_ar_valid_o),
    .mem_ar_ready_i(mem_ar_ready_i),
    .mem_ar_addr_o (mem_ar_addr_o),
    .mem_r_valid_i (mem_r_valid_i),
    .mem_r_ready_o (mem_r_ready_o),
    .mem_r_data_i  (mem_r_data_i),
    .mem_r_resp_i  (mem_r_resp_i),
    .lookup_index_o(lookup_index),
    .lookup_tag_o  (lookup_tag),
    .hit_i         (hit),
    .hit_way_i     (hit_way),
    .alloc_en_o    (alloc_en),
    .alloc_way_o   (alloc_way),
    .alloc_index_o (alloc_index),
    .alloc_tag_o   (alloc_tag),
    .validate_en_o (validate_en),
    .ram_ce_o      (ram_ce),
    .ram_we_o      (ram_we),
    .ram_addr_o    (ram_addr),
    .ram_wdata_o   (ram_wdata),
    .ram0_rdata_i  (ram0_rdata),
    .ram1_rdata_i  (ram1_rdata)
  );

  icache_tag_store #(
    .ADDR_W (ADDR_W),
    .INDEX_W(INDEX_W)
  ) i_icache_tag_store (
    .clk           (clk),
    .rst           (rst),
    .lookup_index_i(lookup_index),
    .lookup_tag_i  (lookup_tag),
    .hit_o         (hit),
    .hit_way_o     (hit_way),
    .alloc_en_i    (alloc_en),
    .alloc_way_i   (alloc_way),
    .alloc_index_i (alloc_index),
    .alloc_tag_i   (alloc_tag),
    .validate_en_i (validate_en)
  );

  // way 0
  icache_data_ram #(
    .INDEX_W(INDEX_W),
    .DATA_W (DATA_W)
  ) i_data_ram0 (
    .clk    (clk),
    .ce_i   (ram_ce[0]),
    .we_i   (ram_we),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .rdata_o(ram0_rdata)
  );

  // way 1
  icache_data_ram #(
    .INDEX_W(INDEX_W),
    .DATA_W (DATA_W)
  ) i_data_ram1 (
    .clk    (clk),
    .ce_i   (ram_ce[1]),
    .we_i   (ram_we),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .rdata_o(ram1_rdata)
  );

endmodule

// ==== icache_properties.sv ====
// icache handshake checks
// bound into icache_top, watches the CPU response and memory address channels

module icache_properties import icache_pkg::*; #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 64
) (
  input logic              clk,
  input logic              rst,
  input logic              ar_ready_i,
  input logic              r_valid_i,
  input logic              r_ready_i,
  input logic [DATA_W-1:0] r_data_i,
  input logic [1:0]        r_resp_i,
  input logic              mem_ar_valid_i,
  input logic              mem_ar_ready_i,
  input logic [ADDR_W-1:0] mem_ar_addr_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // refill address held until memory takes it
  mem_ar_hold: assert property (@(posedge clk) disable iff (rst)
    mem_ar_valid_i && !mem_ar_ready_i |=> mem_ar_valid_i && $stable(mem_ar_addr_i))
    else $error("memory address request dropped or changed before ready");

  r_hold: assert property (@(posedge clk) disable iff (rst)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_resp_i))
    else $error("read response dropped or changed before ready");

  // one request in flight
  no_accept_during_resp: assert property (@(posedge clk) disable iff (rst)
    r_valid_i |-> !ar_ready_i)
    else $error("request port ready while a response is pending");

  resp_code: assert property (@(posedge clk) disable iff (rst)
    r_valid_i |-> (r_resp_i == OKAY || r_resp_i == SLVERR))
    else $error("unknown response code on the read channel");

endmodule

bind icache_top icache_properties #(
  .ADDR_W(ADDR_W),
  .DATA_W(DATA_W)
) i_icache_properties (
  .clk           (clk),
  .rst           (rst),
  .ar_ready_i    (ar_ready_o),
  .r_valid_i     (r_valid_o),
  .r_ready_i     (r_ready_i),
  .r_data_i      (r_data_o),
  .r_resp_i      (r_resp_o),
  .mem_ar_valid_i(mem_ar_valid_o),
  .mem_ar_ready_i(mem_ar_ready_i),
  .mem_ar_addr_i (mem_ar_addr_o)
);

// ==== tb_icache.sv ====
// icache testbench
// directed fetch tests against a memory model with random 0-3 cycle delays
// inputs change on the rising edge, outputs are sampled on the falling edge

module tb_icache import icache_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          ADDR_W         = ADDR_W_DEF;
  localparam int          DATA_W         = DATA_W_DEF;
  localparam int          TIMEOUT_CYCLES = 5000;  // ~30 fetches of at most ~20 cycles each
  localparam logic [31:0] ADDR_A         = 32'h1000_0124;  // index 36, offset 4
  localparam logic [31:0] ADDR_D         = 32'h2000_0330;  // index 38
  localparam logic [31:0] ERR_ADDR       = 32'h0000_5a40;  // memory answers SLVERR here
  localparam logic [31:0] SET_X          = 32'h0000_0a08;  // index 1

  logic              clk;
  logic              rst;
  logic              ar_valid;
  logic              ar_ready;
  logic [ADDR_W-1:0] ar_addr;
  logic              r_valid;
  logic              r_ready;
  logic [DATA_W-1:0] r_data;
  logic [1:0]        r_resp;
  logic              mem_ar_valid;
  logic              mem_ar_ready;
  logic [ADDR_W-1:0] mem_ar_addr;
  logic              mem_r_valid;
  logic              mem_r_ready;
  logic [DATA_W-1:0] mem_r_data;
  logic [1:0]        mem_r_resp;

  int                cycle_count  = 0;
  int                refill_count = 0;
  logic [ADDR_W-1:0] last_refill_addr = '0;
  int                err_count    = 0;
  int                check_count  = 0;
  int                test_count   = 0;

  // result of the last fetch
  logic [DATA_W-1:0] res_data;
  logic [1:0]        res_resp;
  int                res_lat;      // rising edges from the accept edge to r_valid
  int                res_refills;
  logic [ADDR_W-1:0] res_ref_addr;
  int                res_acc_cyc;

  icache_top i_icache_top (
    .clk           (clk),
    .rst           (rst),
    .ar_valid_i    (ar_valid),
    .ar_ready_o    (ar_ready),
    .ar_addr_i     (ar_addr),
    .r_valid_o     (r_valid),
    .r_ready_i     (r_ready),
    .r_data_o      (r_data),
    .r_resp_o      (r_resp),
    .mem_ar_valid_o(mem_ar_valid),
    .mem_ar_ready_i(mem_ar_ready),
    .mem_ar_addr_o (mem_ar_addr),
    .mem_r_valid_i (mem_r_valid),
    .mem_r_ready_o (mem_r_ready),
    .mem_r_data_i  (mem_r_data),
    .mem_r_resp_i  (mem_r_resp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic logic [31:0] line_addr(input logic [31:0] addr);
    return addr & ~32'h7;
  endfunction

  // memory content: line address next to its inverse
  function automatic logic [63:0] mem_word(input logic [31:0] addr);
    logic [31:0] a;
    a = line_addr(addr);
    return {a, ~a};
  endfunction

  // memory model, one refill at a time
  initial begin : mem_responder
    int          ar_wait;
    int          r_wait;
    logic        ar_ready_nx;
    logic        r_valid_nx;
    logic        new_req;
    logic [31:0] pend_addr;
    void'($urandom(56390));
    mem_ar_ready = 1'b0;
    mem_r_valid  = 1'b0;
    mem_r_data   = '0;
    mem_r_resp   = 2'b00;
    pend_addr    = '0;
    ar_wait      = $urandom_range(3, 0);
    r_wait       = 0;
    forever begin
      @(negedge clk);
      ar_ready_nx = mem_ar_ready;
      r_valid_nx  = mem_r_valid;
      new_req     = 1'b0;
      if (mem_ar_valid && mem_ar_ready) begin  // address taken on the coming edge
        ar_ready_nx = 1'b0;
        new_req     = 1'b1;
        pend_addr   = mem_ar_addr;
        ar_wait     = $urandom_range(3, 0);
        r_wait      = $urandom_range(3, 0);
      end else if (mem_ar_valid) begin
        if (ar_wait == 0) begin
          ar_ready_nx = 1'b1;
        end else begin
          ar_wait--;
        end
      end
      if (mem_r_valid && mem_r_ready) begin
        r_valid_nx = 1'b0;
      end else if (mem_r_ready) begin
        if (r_wait == 0) begin
          r_valid_nx = 1'b1;
        end else begin
          r_wait--;
        end
      end
      @(posedge clk);
      mem_ar_ready <= ar_ready_nx;
      mem_r_valid  <= r_valid_nx;
      mem_r_data   <= mem_word(pend_addr);
      mem_r_resp   <= (pend_addr == ERR_ADDR) ? SLVERR : OKAY;
      if (new_req) begin
        refill_count     <= refill_count + 1;
        last_refill_addr <= pend_addr;
      end
    end
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    check_count++;
    assert (cond) else begin
      err_count++;
      $display("error at t=%0t: %s", $time, what);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // handshake outputs right after reset, before any request
  task automatic check_reset_state();
    @(negedge clk);
    check_val("ar_ready_o", 64'(ar_ready), 64'd1);
    check_val("r_valid_o", 64'(r_valid), 64'd0);
    check_val("mem_ar_valid_o", 64'(mem_ar_valid), 64'd0);
    check_val("mem_r_ready_o", 64'(mem_r_ready), 64'd0);
  endtask

  // one CPU read; r_ready stays low for hold cycles once r_valid is up
  // want_par >= 0 delays the request until the accept edge has that parity
  task automatic fetch(input logic [31:0] addr, input int hold, input int want_par);
    int rc0;
    @(negedge clk);
    while (want_par >= 0 && cycle_count % 2 != want_par) begin
      @(negedge clk);
    end
    rc0 = refill_count;
    @(posedge clk);
    ar_valid <= 1'b1;
    ar_addr  <= addr;
    @(negedge clk);
    while (!ar_ready) begin
      @(negedge clk);
    end
    @(posedge clk);  // accept edge
    ar_valid <= 1'b0;
    @(negedge clk);
    res_acc_cyc = cycle_count;
    res_lat     = 0;
    while (!r_valid) begin
      @(negedge clk);
      res_lat++;
    end
    res_data     = r_data;
    res_resp     = r_resp;
    res_refills  = refill_count - rc0;
    res_ref_addr = last_refill_addr;
    repeat (hold) begin
      @(negedge clk);
      check_val("r_valid_o", 64'(r_valid), 64'd1);
      check_val("r_data_o", r_data, res_data);
      check_val("r_resp_o", 64'(r_resp), 64'(res_resp));
      check_val("ar_ready_o", 64'(ar_ready), 64'd0);
    end
    @(posedge clk);
    r_ready <= 1'b1;
    @(posedge clk);  // response handshake
    r_ready <= 1'b0;
  endtask

  task automatic test_cold_miss();
    int e0;
    e0 = err_count;
    check_reset_state();
    fetch(ADDR_A, 0, -1);
    check_val("refill count", 64'(res_refills), 64'd1);
    check_val("mem_ar_addr_o", 64'(res_ref_addr), 64'(line_addr(ADDR_A)));
    check_val("r_data_o", res_data, mem_word(ADDR_A));
    check_val("r_resp_o", 64'(res_resp), 64'(OKAY));
    report_test("cold miss", e0);
  endtask

  task automatic test_hit();
    int e0;
    e0 = err_count;
    fetch(ADDR_A, 0, -1);
    check_val("refill count", 64'(res_refills), 64'd0);
    check_val("r_data_o", res_data, mem_word(ADDR_A));
    check_val("r_resp_o", 64'(res_resp), 64'(OKAY));
    check_val("hit latency", 64'(res_lat), 64'd2);
    report_test("hit", e0);
  endtask

  task automatic test_offset_ignored();
    int e0;
    e0 = err_count;
    for (int off = 0; off < 8; off++) begin
      fetch(line_addr(ADDR_A) | 32'(off), 0, -1);
      check_val("refill count", 64'(res_refills), 64'd0);
      check_val("r_data_o", res_data, mem_word(ADDR_A));
    end
    report_test("offset ignored", e0);
  endtask

  task automatic test_two_way();
    int          e0;
    int          par;
    int          total;
    logic [31:0] addr [3];
    e0      = err_count;
    addr[0] = SET_X;
    addr[1] = SET_X | 32'h0010_0000;  // same index, other tags
    addr[2] = SET_X | 32'h0020_0000;
    fetch(addr[0], 0, -1);
    check_val("refill count", 64'(res_refills), 64'd1);
    par = res_acc_cyc % 2;
    fetch(addr[1], 0, 1 - par);  // replacement counter points at the other way
    check_val("refill count", 64'(res_refills), 64'd1);
    check_val("r_data_o", res_data, mem_word(addr[1]));
    for (int i = 0; i < 2; i++) begin
      fetch(addr[i], 0, -1);
      check_val("refill count", 64'(res_refills), 64'd0);
      check_val("r_data_o", res_data, mem_word(addr[i]));
    end
    fetch(addr[2], 0, -1);
    check_val("refill count", 64'(res_refills), 64'd1);
    total = 0;
    for (int i = 0; i < 3; i++) begin
      fetch(addr[i], 0, -1);
      check_val("r_data_o", res_data, mem_word(addr[i]));
      check_val("r_resp_o", 64'(res_resp), 64'(OKAY));
      total += res_refills;
    end
    check_cond(total >= 1, "three lines of one set re-read without any refill");
    report_test("two way", e0);
  endtask

  task automatic test_error_refill();
    int e0;
    e0 = err_count;
    repeat (2) begin  // an error line is never kept
      fetch(ERR_ADDR, 0, -1);
      check_val("refill count", 64'(res_refills), 64'd1);
      check_val("r_resp_o", 64'(res_resp), 64'(SLVERR));
      check_val("r_data_o", res_data, mem_word(ERR_ADDR));
    end
    report_test("error refill", e0);
  endtask

  task automatic test_back_pressure();
    int e0;
    e0 = err_count;
    fetch(ADDR_A, 6, -1);
    check_val("r_data_o", res_data, mem_word(ADDR_A));
    fetch(ADDR_D, 5, -1);
    check_val("refill count", 64'(res_refills), 64'd1);
    check_val("r_data_o", res_data, mem_word(ADDR_D));
    report_test("back pressure", e0);
  endtask

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(negedge clk);
    end
    $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    rst      = 1'b1;
    ar_valid = 1'b0;
    ar_addr  = '0;
    r_ready  = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    test_cold_miss();
    test_hit();
    test_offset_ignored();
    test_two_way();
    test_error_refill();
    test_back_pressure();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
icache_pkg.sv
icache_data_ram.sv
icache_tag_store.sv
icache_ctrl.sv
icache_top.sv
icache_properties.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the icache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_icache -f filelist.f -o tb_icache_sim \
  && ./obj_dir/tb_icache_sim 2>&1 | tee sim.log

grep -q "SIMULATION PASSED" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }
